// File: ntm_float_macros.svh
////////////////////////////////////////////////////////////
// Shared widths and timing for the float divider blocks
// Include in every RTL file before the package import
////////////////////////////////////////////////////////////

`ifndef NTM_FLOAT_MACROS_SVH
`define NTM_FLOAT_MACROS_SVH

// Single precision float word
`define NTM_DATA_SIZE 32

// Matrix dimensions and loop indices
`define NTM_CONTROL_SIZE 8

// Quotient bits produced by the iterative divider
// One integer bit plus 25 fraction bits
`define NTM_DIV_CYCLES 26

`endif

// File: ntm_float_pkg.sv
////////////////////////////////////////////////////////////
// Float field types and FSM encodings for the divider tree
// Imported with a wildcard by each divider module
////////////////////////////////////////////////////////////

`include "ntm_float_macros.svh"

package ntm_float_pkg;

  // Data words and fields
  typedef logic [`NTM_DATA_SIZE-1:0] float_word_t;
  // Signed so exponent difference can go negative
  typedef logic signed [9:0] float_exp_t;
  // Mantissa with hidden bit in front
  typedef logic [23:0] float_mant_t;
  typedef logic [`NTM_CONTROL_SIZE-1:0] ctrl_index_t;

  // Scalar divider FSM
  typedef enum logic [1:0] {SCAL_IDLE, SCAL_DIVIDE, SCAL_PACK} scalar_state_t;

  // Vector row FSM
  typedef enum logic [1:0] {VEC_IDLE, VEC_INPUT, VEC_WAIT} vector_state_t;

  // Matrix walk FSM
  typedef enum logic [1:0] {STARTER, INPUT_I, INPUT_J, ENDER} matrix_state_t;

endpackage

// File: ntm_scalar_float_divider.sv
////////////////////////////////////////////////////////////
// Iterative single precision divider, one quotient per start
// Normal operands take 28 cycles, special cases take 2
// Result is truncated, subnormals are treated as zero
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "ntm_float_macros.svh"

module ntm_scalar_float_divider
  import ntm_float_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  float_word_t a_in,
  input  float_word_t b_in,
  output logic        ready,
  output float_word_t data_out
);

  localparam int CNT_W = $clog2(`NTM_DIV_CYCLES);
  localparam float_word_t CANON_NAN = 32'h7FC0_0000;

  ////////////////////////////////////////////////////////////
  // Operand classification
  ////////////////////////////////////////////////////////////

  logic [7:0] a_exp;
  logic [7:0] b_exp;
  logic       a_zero;
  logic       b_zero;
  logic       a_inf;
  logic       b_inf;
  logic       a_nan;
  logic       b_nan;
  logic       res_sign;
  logic       spec_nan;
  logic       spec_inf;
  logic       spec_zero;
  float_word_t special_val;

  assign a_exp = a_in[30:23];
  assign b_exp = b_in[30:23];
  // Exponent zero covers subnormals too
  assign a_zero = (a_exp == 8'h00);
  assign b_zero = (b_exp == 8'h00);
  assign a_inf = (a_exp == 8'hFF) && (a_in[22:0] == '0);
  assign b_inf = (b_exp == 8'hFF) && (b_in[22:0] == '0);
  assign a_nan = (a_exp == 8'hFF) && (a_in[22:0] != '0);
  assign b_nan = (b_exp == 8'hFF) && (b_in[22:0] != '0);
  assign res_sign = a_in[31] ^ b_in[31];

  // Priority: NaN first, then infinity, then zero
  assign spec_nan = a_nan | b_nan | (a_zero & b_zero) | (a_inf & b_inf);
  assign spec_inf = a_inf | b_zero;
  assign spec_zero = a_zero | b_inf;

  always_comb begin
    if (spec_nan) begin
      special_val = CANON_NAN;
    end else if (spec_inf) begin
      special_val = {res_sign, 8'hFF, 23'h0};
    end else begin
      special_val = {res_sign, 31'h0};
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////////////////////////

  scalar_state_t              state;
  logic [CNT_W-1:0]           cnt;
  logic                       sign_r;
  float_exp_t                 exp_r;
  logic [24:0]                rem_r;
  float_mant_t                div_r;
  logic [`NTM_DIV_CYCLES-1:0] quo_r;
  logic                       special_r;
  float_word_t                special_word;

  // Restoring step
  logic        rem_ge;
  logic [24:0] rem_sub;

  assign rem_ge = (rem_r >= {1'b0, div_r});
  assign rem_sub = rem_ge ? (rem_r - {1'b0, div_r}) : rem_r;

  // Pack and normalize, quotient lies in (0.5, 2)
  logic        q_norm;
  float_exp_t  exp_adj;
  logic [22:0] frac;
  float_word_t pack_word;

  assign q_norm = quo_r[25];
  assign exp_adj = q_norm ? exp_r : (exp_r - 10'sd1);
  assign frac = q_norm ? quo_r[24:2] : quo_r[23:1];

  always_comb begin
    if (special_r) begin
      pack_word = special_word;
    end else if (exp_adj <= 10'sd0) begin
      // Underflow flushes to signed zero
      pack_word = {sign_r, 31'h0};
    end else if (exp_adj >= 10'sd255) begin
      pack_word = {sign_r, 8'hFF, 23'h0};
    end else begin
      pack_word = {sign_r, exp_adj[7:0], frac};
    end
  end

  // Operand capture and division steps
  always_ff @(posedge CLK) begin
    if (state == SCAL_IDLE && start) begin
      sign_r <= res_sign;
      exp_r <= float_exp_t'({2'b00, a_exp}) - float_exp_t'({2'b00, b_exp}) + 10'sd127;
      rem_r <= {2'b01, a_in[22:0]};
      div_r <= {1'b1, b_in[22:0]};
      quo_r <= '0;
      special_r <= spec_nan | spec_inf | spec_zero;
      special_word <= special_val;
    end else if (state == SCAL_DIVIDE) begin
      rem_r <= {rem_sub[23:0], 1'b0};
      quo_r <= {quo_r[`NTM_DIV_CYCLES-2:0], rem_ge};
    end
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= SCAL_IDLE;
      cnt <= '0;
      ready <= 1'b0;
      data_out <= '0;
    end else begin
      ready <= 1'b0;
      case (state)
        SCAL_IDLE: begin
          if (start) begin
            cnt <= CNT_W'(`NTM_DIV_CYCLES - 1);
            // Special cases skip the division loop
            if (spec_nan | spec_inf | spec_zero) begin
              state <= SCAL_PACK;
            end else begin
              state <= SCAL_DIVIDE;
            end
          end
        end
        SCAL_DIVIDE: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            state <= SCAL_PACK;
          end
        end
        SCAL_PACK: begin
          data_out <= pack_word;
          ready <= 1'b1;
          state <= SCAL_IDLE;
        end
        default: state <= SCAL_IDLE;
      endcase
    end
  end

  // Caller waits for ready before the next start
  a_start_idle: assert property (@(posedge CLK) disable iff (RST)
    start |-> state == SCAL_IDLE);

endmodule

// File: ntm_vector_divider.sv
////////////////////////////////////////////////////////////
// Row divider, takes element pairs one at a time
// Starts the scalar divider once both operands are held
// ready marks the last element of the row
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "ntm_float_macros.svh"

module ntm_vector_divider
  import ntm_float_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  ctrl_index_t size_in,
  input  logic        a_enable,
  input  logic        b_enable,
  input  float_word_t a_in,
  input  float_word_t b_in,
  output logic        out_enable,
  output float_word_t data_out,
  output logic        ready
);

  vector_state_t state;
  ctrl_index_t   index;
  float_word_t   a_reg;
  float_word_t   b_reg;
  logic          a_held;
  logic          b_held;

  // Scalar divider handshake
  logic          scal_start;
  logic          scal_ready;
  float_word_t   scal_out;

  // Fires in the first cycle both operands are held
  assign scal_start = (state == VEC_INPUT) && a_held && b_held;

  // Operand holding registers
  always_ff @(posedge CLK) begin
    if (state == VEC_INPUT && a_enable && !a_held) begin
      a_reg <= a_in;
    end
    if (state == VEC_INPUT && b_enable && !b_held) begin
      b_reg <= b_in;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= VEC_IDLE;
      index <= '0;
      a_held <= 1'b0;
      b_held <= 1'b0;
      out_enable <= 1'b0;
      ready <= 1'b0;
      data_out <= '0;
    end else begin
      out_enable <= 1'b0;
      ready <= 1'b0;
      case (state)
        VEC_IDLE: begin
          if (start) begin
            index <= '0;
            state <= VEC_INPUT;
          end
        end
        VEC_INPUT: begin
          if (a_enable) a_held <= 1'b1;
          if (b_enable) b_held <= 1'b1;
          // Both held, hand the pair over
          if (scal_start) begin
            a_held <= 1'b0;
            b_held <= 1'b0;
            state <= VEC_WAIT;
          end
        end
        VEC_WAIT: begin
          // Late enables are dropped here
          if (scal_ready) begin
            out_enable <= 1'b1;
            data_out <= scal_out;
            if (index == size_in - 1'b1) begin
              ready <= 1'b1;
              state <= VEC_IDLE;
            end else begin
              index <= index + 1'b1;
              state <= VEC_INPUT;
            end
          end
        end
        default: state <= VEC_IDLE;
      endcase
    end
  end

  ntm_scalar_float_divider scalar_divider (
    .CLK      (CLK),
    .RST      (RST),
    .start    (scal_start),
    .a_in     (a_reg),
    .b_in     (b_reg),
    .ready    (scal_ready),
    .data_out (scal_out)
  );

  // Output pulses follow each scalar result, and only a scalar result
  a_out_after_scal: assert property (@(posedge CLK) disable iff (RST)
    (out_enable || ready) == $past(scal_ready));

endmodule

// File: ntm_matrix_float_divider.sv
////////////////////////////////////////////////////////////
// Top level, element-wise division of two I x J matrices
// Pulse start with sizes, then offer A/B pairs per element
// i enables for the first column, j enables for the rest
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "ntm_float_macros.svh"

module ntm_matrix_float_divider
  import ntm_float_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  output logic        ready,
  input  logic        data_a_in_i_enable,
  input  logic        data_a_in_j_enable,
  input  logic        data_b_in_i_enable,
  input  logic        data_b_in_j_enable,
  output logic        data_out_i_enable,
  output logic        data_out_j_enable,
  input  ctrl_index_t size_i_in,
  input  ctrl_index_t size_j_in,
  input  float_word_t data_a_in,
  input  float_word_t data_b_in,
  output float_word_t data_out
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  matrix_state_t state;
  ctrl_index_t   size_i_r;
  ctrl_index_t   size_j_r;
  ctrl_index_t   index_i;
  ctrl_index_t   index_j;
  logic          a_got;
  logic          b_got;
  logic          a_take;
  logic          b_take;
  logic          last_j;
  logic          last_i;

  // Vector divider handshake
  logic          vec_start;
  logic          vec_a_enable;
  logic          vec_b_enable;
  float_word_t   vec_a;
  float_word_t   vec_b;
  logic          vec_out_enable;
  logic          vec_ready;
  float_word_t   vec_out;

  // First column uses i enables, the others j enables
  assign a_take = !a_got && ((state == INPUT_I) ? data_a_in_i_enable :
                             (state == INPUT_J) ? data_a_in_j_enable : 1'b0);
  assign b_take = !b_got && ((state == INPUT_I) ? data_b_in_i_enable :
                             (state == INPUT_J) ? data_b_in_j_enable : 1'b0);
  assign last_j = (index_j == size_j_r - 1'b1);
  assign last_i = (index_i == size_i_r - 1'b1);

  // Forwarded operands
  always_ff @(posedge CLK) begin
    if (a_take) vec_a <= data_a_in;
    if (b_take) vec_b <= data_b_in;
  end

  ////////////////////////////////////////////////////////////
  // Matrix walk
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= STARTER;
      size_i_r <= '0;
      size_j_r <= '0;
      index_i <= '0;
      index_j <= '0;
      a_got <= 1'b0;
      b_got <= 1'b0;
      vec_start <= 1'b0;
      vec_a_enable <= 1'b0;
      vec_b_enable <= 1'b0;
      ready <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      data_out <= '0;
    end else begin
      // One cycle pulses by default
      vec_start <= 1'b0;
      vec_a_enable <= a_take;
      vec_b_enable <= b_take;
      ready <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      case (state)
        STARTER: begin
          if (start) begin
            size_i_r <= size_i_in;
            size_j_r <= size_j_in;
            index_i <= '0;
            index_j <= '0;
            vec_start <= 1'b1;
            state <= INPUT_I;
          end
        end
        INPUT_I, INPUT_J: begin
          if (a_take) a_got <= 1'b1;
          if (b_take) b_got <= 1'b1;
          // Pair complete, wait for the quotient
          if ((a_got || a_take) && (b_got || b_take)) begin
            a_got <= 1'b0;
            b_got <= 1'b0;
            state <= ENDER;
          end
        end
        ENDER: begin
          if (vec_out_enable) begin
            data_out <= vec_out;
            data_out_j_enable <= 1'b1;
            if (last_j && last_i) begin
              ready <= 1'b1;
              state <= STARTER;
            end else if (last_j) begin
              // Row done, next row opens a new vector pass
              data_out_i_enable <= 1'b1;
              index_i <= index_i + 1'b1;
              index_j <= '0;
              vec_start <= 1'b1;
              state <= INPUT_I;
            end else begin
              index_j <= index_j + 1'b1;
              state <= INPUT_J;
            end
          end
        end
        default: state <= STARTER;
      endcase
    end
  end

  ntm_vector_divider vector_divider (
    .CLK        (CLK),
    .RST        (RST),
    .start      (vec_start),
    .size_in    (size_j_r),
    .a_enable   (vec_a_enable),
    .b_enable   (vec_b_enable),
    .a_in       (vec_a),
    .b_in       (vec_b),
    .out_enable (vec_out_enable),
    .data_out   (vec_out),
    .ready      (vec_ready)
  );

  // Matrix done only ever comes with an element that ended a vector pass
  a_ready_with_elem: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_j_enable && $past(vec_ready));

  // Vector row count agrees with the column index
  a_row_end_match: assert property (@(posedge CLK) disable iff (RST)
    vec_out_enable |-> (vec_ready == last_j));

endmodule

// File: tb_clock_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset source
// 100 ns clock, reset held high for the first 4 cycles
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  // Free running clock, 50 ns per phase
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Release on a falling edge, away from DUT sampling
  initial begin
    RST = 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

// File: ntm_matrix_float_divider_tb.sv
////////////////////////////////////////////////////////////
// Table driven testbench for the matrix float divider
// Each group of table rows forms one matrix, applied in order
// Operand order within a pair is randomized
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "ntm_float_macros.svh"

module ntm_matrix_float_divider_tb
  import ntm_float_pkg::*;
();

  localparam int NUM_ELEMS = 19;
  localparam int NUM_MATS = 5;
  // Per element bound, normal latency is about 31 cycles
  localparam int ELEM_WAIT = 40;
  localparam int CYCLE_LIMIT = NUM_ELEMS * ELEM_WAIT + 200;

  // Matrix shapes, rows of the table taken in order
  localparam int MAT_I [NUM_MATS] = '{2, 2, 3, 1, 1};
  localparam int MAT_J [NUM_MATS] = '{3, 2, 2, 2, 1};

  // Operand A, operand B, expected quotient
  localparam logic [95:0] VECTORS [NUM_ELEMS] = '{
    // 2x3 normal values
    {32'h40C0_0000, 32'h4000_0000, 32'h4040_0000},  // 6 / 2
    {32'hBF80_0000, 32'h4080_0000, 32'hBE80_0000},  // -1 / 4
    {32'h3F80_0000, 32'h4040_0000, 32'h3EAA_AAAA},  // 1 / 3, truncated
    {32'h4120_0000, 32'hC080_0000, 32'hC020_0000},  // 10 / -4
    {32'h4040_0000, 32'h4000_0000, 32'h3FC0_0000},  // 3 / 2
    {32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0000},  // 1 / 1
    // 2x2 zero and NaN cases
    {32'h40A0_0000, 32'h0000_0000, 32'h7F80_0000},  // 5 / 0
    {32'h0000_0000, 32'hC040_0000, 32'h8000_0000},  // 0 / -3
    {32'h0000_0000, 32'h0000_0000, 32'h7FC0_0000},  // 0 / 0
    {32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0000},  // NaN / 1
    // 3x2 infinities, overflow, underflow, subnormal
    {32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000},  // inf / -inf
    {32'hFF80_0000, 32'h4000_0000, 32'hFF80_0000},  // -inf / 2
    {32'h3F80_0000, 32'hFF80_0000, 32'h8000_0000},  // 1 / -inf
    {32'h7F00_0000, 32'h0080_0000, 32'h7F80_0000},  // 2^127 / 2^-126
    {32'h8080_0000, 32'h7F00_0000, 32'h8000_0000},  // -2^-126 / 2^127
    {32'h0040_0000, 32'hBF80_0000, 32'h8000_0000},  // subnormal / -1
    // 1x2, 1e38 over a subnormal 1e-38 then x / inf
    {32'h7E96_7699, 32'h006C_E3EE, 32'h7F80_0000},
    {32'h3F80_0000, 32'h7F80_0000, 32'h0000_0000},
    // 1x1 single element
    {32'h4100_0000, 32'h4080_0000, 32'h4000_0000}   // 8 / 4
  };

  logic        CLK;
  logic        RST;
  logic        start;
  logic        ready;
  logic        data_a_in_i_enable;
  logic        data_a_in_j_enable;
  logic        data_b_in_i_enable;
  logic        data_b_in_j_enable;
  logic        data_out_i_enable;
  logic        data_out_j_enable;
  ctrl_index_t size_i_in;
  ctrl_index_t size_j_in;
  float_word_t data_a_in;
  float_word_t data_b_in;
  float_word_t data_out;

  int seed = 32'h48d7_9402;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int cycles = 0;
  logic timed_out = 1'b0;

  tb_clock_gen clock_gen (
    .CLK (CLK),
    .RST (RST)
  );

  ntm_matrix_float_divider dut0 (
    .CLK                (CLK),
    .RST                (RST),
    .start              (start),
    .ready              (ready),
    .data_a_in_i_enable (data_a_in_i_enable),
    .data_a_in_j_enable (data_a_in_j_enable),
    .data_b_in_i_enable (data_b_in_i_enable),
    .data_b_in_j_enable (data_b_in_j_enable),
    .data_out_i_enable  (data_out_i_enable),
    .data_out_j_enable  (data_out_j_enable),
    .size_i_in          (size_i_in),
    .size_j_in          (size_j_in),
    .data_a_in          (data_a_in),
    .data_b_in          (data_b_in),
    .data_out           (data_out)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // No output pulse may appear without an element pending
  task automatic check_quiet();
    if (ready || data_out_i_enable || data_out_j_enable) begin
      $display("[ERROR] %0t: output pulse with no element pending", $time);
      errors++;
    end
  endtask

  // First column uses the i enables
  task automatic set_enables(input logic a_on, input logic b_on, input logic first_col);
    data_a_in_i_enable = a_on && first_col;
    data_a_in_j_enable = a_on && !first_col;
    data_b_in_i_enable = b_on && first_col;
    data_b_in_j_enable = b_on && !first_col;
  endtask

  task automatic start_matrix(input int rows, input int cols);
    @(negedge CLK);
    check_quiet();
    start = 1'b1;
    size_i_in = ctrl_index_t'(rows);
    size_j_in = ctrl_index_t'(cols);
    @(negedge CLK);
    check_quiet();
    start = 1'b0;
  endtask

  task automatic offer_pair(input float_word_t a, input float_word_t b, input logic first_col);
    int order;
    order = $random(seed) & 3;
    @(negedge CLK);
    check_quiet();
    data_a_in = a;
    data_b_in = b;
    if (order == 1) begin
      // A one cycle ahead of B
      set_enables(1'b1, 1'b0, first_col);
      @(negedge CLK);
      check_quiet();
      set_enables(1'b0, 1'b1, first_col);
    end else if (order == 2) begin
      set_enables(1'b0, 1'b1, first_col);
      @(negedge CLK);
      check_quiet();
      set_enables(1'b1, 1'b0, first_col);
    end else begin
      set_enables(1'b1, 1'b1, first_col);
    end
    @(negedge CLK);
    check_quiet();
    set_enables(1'b0, 1'b0, first_col);
  endtask

  // Sample on falling edges until the element pulse
  task automatic wait_result(output float_word_t val, output logic row_end,
                             output logic done, output logic got);
    int waited;
    waited = 0;
    got = 1'b0;
    val = '0;
    row_end = 1'b0;
    done = 1'b0;
    while (!got && waited < ELEM_WAIT) begin
      @(negedge CLK);
      waited++;
      if (data_out_j_enable) begin
        got = 1'b1;
        val = data_out;
        row_end = data_out_i_enable;
        done = ready;
      end else begin
        check_quiet();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    float_word_t got_val;
    logic        got_row_end;
    logic        got_done;
    logic        got;
    logic        exp_row_end;
    logic        exp_done;
    int          elem;
    int          mat_errors;
    start = 1'b0;
    size_i_in = '0;
    size_j_in = '0;
    data_a_in = '0;
    data_b_in = '0;
    set_enables(1'b0, 1'b0, 1'b0);
    elem = 0;
    // Outputs idle through reset and a few cycles after
    repeat (2) begin
      @(negedge CLK);
      check_quiet();
    end
    wait (RST == 1'b0);
    repeat (3) begin
      @(negedge CLK);
      check_quiet();
    end
    for (int mat = 0; mat < NUM_MATS && !timed_out; mat++) begin
      mat_errors = errors;
      start_matrix(MAT_I[mat], MAT_J[mat]);
      for (int ii = 0; ii < MAT_I[mat] && !timed_out; ii++) begin
        for (int jj = 0; jj < MAT_J[mat] && !timed_out; jj++) begin
          offer_pair(VECTORS[elem][95:64], VECTORS[elem][63:32], jj == 0);
          wait_result(got_val, got_row_end, got_done, got);
          // Row pulse on every row end but the last, done on the final element
          exp_row_end = (jj == MAT_J[mat] - 1) && (ii < MAT_I[mat] - 1);
          exp_done = (ii == MAT_I[mat] - 1) && (jj == MAT_J[mat] - 1);
          if (!got) begin
            $display("Timeout: element %0d gave no result within %0d cycles", elem, ELEM_WAIT);
            timed_out = 1'b1;
            errors++;
          end
          if (got && got_val != VECTORS[elem][31:0]) begin
            $display("[ERROR] %0t: element %0d quotient %h, expected %h",
                     $time, elem, got_val, VECTORS[elem][31:0]);
            errors++;
          end
          if (got && got_row_end != exp_row_end) begin
            $display("[ERROR] %0t: element %0d row end %b, expected %b",
                     $time, elem, got_row_end, exp_row_end);
            errors++;
          end
          if (got && got_done != exp_done) begin
            $display("[ERROR] %0t: element %0d ready %b, expected %b",
                     $time, elem, got_done, exp_done);
            errors++;
          end
          elem++;
        end
      end
      // No second ready or stray element once the matrix is done
      repeat (2) begin
        @(negedge CLK);
        check_quiet();
      end
      tests++;
      if (errors != mat_errors) failed_tests++;
      $display("Test %0d: %0dx%0d matrix %s", mat, MAT_I[mat], MAT_J[mat],
               (errors == mat_errors) ? "passed" : "failed");
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Global cycle limit
  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: run reached the limit of %0d cycles", CYCLE_LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
ntm_float_pkg.sv
ntm_scalar_float_divider.sv
ntm_vector_divider.sv
ntm_matrix_float_divider.sv
tb_clock_gen.sv
ntm_matrix_float_divider_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ntm_matrix_float_divider_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = CHECKS FAILED
PASS_MSG = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
